//--- include/twdl_params.svh
`ifndef TWDL_PARAMS_SVH
`define TWDL_PARAMS_SVH

// Sample and coefficient widths.
`define TW_DATA_W 30
`define TW_COEF_W 18
`define TW_FRAC 17

// One lane per butterfly leg.
`define TW_LANES 5
`define TW_FACTOR_W 3
`define TW_FACTOR_MIN 2
`define TW_FACTOR_MAX 5

// Twiddle table covers the 256-point unit circle.
`define TW_ROM_AW 8
`define TW_ROM_DEPTH (1 << `TW_ROM_AW)

// Config register map.
`define TW_REG_FACTOR 2'd0
`define TW_REG_STEP 2'd1
`define TW_REG_CEIL 2'd2
`define TW_REG_TIME 2'd3

`endif

//--- hdl/fft_data_pkg.sv
`include "twdl_params.svh"

package fft_data_pkg;

	// One real or imaginary sample component.
	typedef logic signed [`TW_DATA_W-1:0] sample_t;

	typedef struct packed
	{
		sample_t re;
		sample_t im;
	} cplx_t;

	// All lanes of one beat, lane 0 in the low bits.
	typedef cplx_t [`TW_LANES-1:0] lane_vec_t;

	// Twiddle component, Q1.17.
	typedef logic signed [`TW_COEF_W-1:0] coef_t;

	typedef struct packed
	{
		coef_t re;
		coef_t im;
	} tw_cplx_t;

endpackage

//--- hdl/twdl_cfg_pkg.sv
`include "twdl_params.svh"

package twdl_cfg_pkg;

	// ROM address, also used for the exponent settings.
	typedef logic [`TW_ROM_AW-1:0] tw_addr_t;

	typedef logic [`TW_FACTOR_W-1:0] factor_t;

	// Live stage configuration.
	typedef struct packed
	{
		factor_t factor;
		tw_addr_t addr_step;
		tw_addr_t exp_ceil;
		tw_addr_t exp_time;
	} twdl_cfg_t;

	typedef enum logic
	{
		CFG_IDLE,
		CFG_PENDING
	} cfg_state_e;

endpackage

//--- hdl/twdl_cfg_regs.sv
`timescale 1ns/1ps
`include "twdl_params.svh"

module twdl_cfg_regs
(
	input  logic clk,
	input  logic rst_n,
	input  logic cfg_we,
	input  logic [1:0] cfg_addr,
	input  twdl_cfg_pkg::tw_addr_t cfg_wdata,
	input  logic in_val,
	output twdl_cfg_pkg::twdl_cfg_t cfg
);
	import twdl_cfg_pkg::*;

	localparam twdl_cfg_t CFG_RESET = '{
		factor: factor_t'(5),
		addr_step: tw_addr_t'(1),
		exp_ceil: tw_addr_t'(1),
		exp_time: tw_addr_t'(1)
	};

	twdl_cfg_t shadow;
	twdl_cfg_t shadow_nxt;
	cfg_state_e state;
	tw_addr_t wdata_clamp;
	logic wr_ok;
	logic commit;

	// Out-of-range factors are dropped; everything else is taken.
	assign wr_ok = cfg_we && ((cfg_addr != `TW_REG_FACTOR) ||
		((cfg_wdata >= `TW_FACTOR_MIN) && (cfg_wdata <= `TW_FACTOR_MAX)));

	// A zero period would never wrap.
	assign wdata_clamp = (cfg_wdata == '0) ? tw_addr_t'(1) : cfg_wdata;

	always_comb
	begin
		shadow_nxt = shadow;
		if (wr_ok)
		begin
			case (cfg_addr)
				`TW_REG_FACTOR: shadow_nxt.factor = factor_t'(cfg_wdata);
				`TW_REG_STEP: shadow_nxt.addr_step = cfg_wdata;
				`TW_REG_CEIL: shadow_nxt.exp_ceil = wdata_clamp;
				`TW_REG_TIME: shadow_nxt.exp_time = wdata_clamp;
			endcase
		end
	end

	// Settings only move to the live set between blocks.
	assign commit = !in_val && (wr_ok || (state == CFG_PENDING));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			shadow <= CFG_RESET;
			cfg <= CFG_RESET;
			state <= CFG_IDLE;
		end
		else
		begin
			shadow <= shadow_nxt;
			if (commit)
			begin
				cfg <= shadow_nxt;
				state <= CFG_IDLE;
			end
			else if (wr_ok)
				state <= CFG_PENDING;
		end
	end

	a_factor_legal: assert property (@(posedge clk) disable iff (!rst_n)
		(cfg.factor >= `TW_FACTOR_MIN) && (cfg.factor <= `TW_FACTOR_MAX));

endmodule

//--- hdl/twdl_rom.sv
`timescale 1ns/1ps
`include "twdl_params.svh"

module twdl_rom
(
	input  logic clk,
	input  twdl_cfg_pkg::tw_addr_t addr,
	output fft_data_pkg::tw_cplx_t tw
);
	import fft_data_pkg::*;

	localparam int DEPTH = `TW_ROM_DEPTH;
	localparam real PI = 3.14159265358979323846;
	localparam real SCALE = real'((1 << `TW_FRAC) - 1);

	tw_cplx_t rom [DEPTH];

	// Half-way cases round away from zero.
	function automatic int round_away(real x);
		int r;
		if (x >= 0.0)
			r = $rtoi(x + 0.5);
		else
			r = -$rtoi(0.5 - x);
		return r;
	endfunction

	// Entry k is exp(-j*2*pi*k/256) in Q1.17.
	initial
	begin
		real ang;
		for (int k = 0; k < DEPTH; k++)
		begin
			ang = 2.0 * PI * k / DEPTH;
			rom[k].re = coef_t'(round_away($cos(ang) * SCALE));
			rom[k].im = coef_t'(-round_away($sin(ang) * SCALE));
		end
	end

	always_ff @(posedge clk)
	begin
		tw <= rom[addr];
	end

endmodule

//--- hdl/twdl_mult.sv
`timescale 1ns/1ps
`include "twdl_params.svh"

module twdl_mult
(
	input  logic clk,
	input  logic rst_n,
	input  twdl_cfg_pkg::twdl_cfg_t cfg,
	input  logic in_val,
	input  fft_data_pkg::lane_vec_t din,
	output logic out_val,
	output fft_data_pkg::lane_vec_t dout
);
	import fft_data_pkg::*;
	import twdl_cfg_pkg::*;

	localparam int LANES = `TW_LANES;
	localparam int PROD_W = `TW_DATA_W + `TW_COEF_W + 1;

	tw_addr_t n_cnt;
	tw_addr_t rep_cnt;
	logic rep_last;
	logic n_last;

	tw_addr_t [LANES-1:0] rd_addr;
	tw_cplx_t [LANES-1:0] tw;
	logic [LANES-1:0] lane_en;
	logic [LANES-1:0] lane_en_r;
	lane_vec_t din_r;
	logic [1:0] val_r;

	// Full-precision complex product, scaled back to sample width.
	function automatic cplx_t cmul(cplx_t d, tw_cplx_t t);
		logic signed [PROD_W-1:0] prod_re;
		logic signed [PROD_W-1:0] prod_im;
		cplx_t r;
		prod_re = d.re * t.re - d.im * t.im;
		prod_im = d.re * t.im + d.im * t.re;
		r.re = sample_t'(prod_re >>> `TW_FRAC);
		r.im = sample_t'(prod_im >>> `TW_FRAC);
		return r;
	endfunction

	assign rep_last = (rep_cnt == tw_addr_t'(cfg.exp_time - 1'b1));
	assign n_last = (n_cnt == tw_addr_t'(cfg.exp_ceil - 1'b1));

	// n steps once every exp_time beats and restarts whenever the stream stops.
	always_ff @(posedge clk)
	begin
		if (!rst_n || !in_val)
		begin
			n_cnt <= '0;
			rep_cnt <= '0;
		end
		else if (rep_last)
		begin
			rep_cnt <= '0;
			n_cnt <= n_last ? '0 : n_cnt + 1'b1;
		end
		else
			rep_cnt <= rep_cnt + 1'b1;
	end

	genvar i;
	generate
		for (i = 0; i < LANES; i++)
		begin : g_lane
			// Modulo 256 falls out of the truncation.
			assign rd_addr[i] = tw_addr_t'(cfg.addr_step * n_cnt * i);
			assign lane_en[i] = in_val && (i < cfg.factor);

			twdl_rom u_rom
			(
				.clk (clk),
				.addr (rd_addr[i]),
				.tw (tw[i])
			);
		end
	endgenerate

	// Stage one lines the data up with the ROM output.
	always_ff @(posedge clk)
	begin
		din_r <= din;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			val_r <= '0;
			lane_en_r <= '0;
		end
		else
		begin
			val_r <= {val_r[0], in_val};
			lane_en_r <= lane_en;
		end
	end

	// Stage two registers the products; disabled lanes read zero.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			dout <= '0;
		else
		begin
			for (int k = 0; k < LANES; k++)
			begin
				if (lane_en_r[k])
					dout[k] <= cmul(din_r[k], tw[k]);
				else
					dout[k] <= '0;
			end
		end
	end

	assign out_val = val_r[1];

	a_val_lat: assert property (@(posedge clk) disable iff (!rst_n)
		in_val |-> ##2 out_val);
	a_idle_lat: assert property (@(posedge clk) disable iff (!rst_n)
		!in_val |-> ##2 !out_val);

endmodule

//--- hdl/twdl_stage.sv
`timescale 1ns/1ps

module twdl_stage
(
	input  logic clk,
	input  logic rst_n,

	input  logic cfg_we,
	input  logic [1:0] cfg_addr,
	input  twdl_cfg_pkg::tw_addr_t cfg_wdata,

	input  logic in_val,
	input  fft_data_pkg::lane_vec_t din,

	output logic out_val,
	output fft_data_pkg::lane_vec_t dout
);
	import twdl_cfg_pkg::*;

	// Live settings seen by the multiplier.
	twdl_cfg_t cfg;

	twdl_cfg_regs u_cfg_regs
	(
		.clk (clk),
		.rst_n (rst_n),
		.cfg_we (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.in_val (in_val),
		.cfg (cfg)
	);

	twdl_mult u_mult
	(
		.clk (clk),
		.rst_n (rst_n),
		.cfg (cfg),
		.in_val (in_val),
		.din (din),
		.out_val (out_val),
		.dout (dout)
	);

endmodule

//--- dv/tb_twdl_stage.sv
`timescale 1ns/1ps
`include "twdl_params.svh"

module tb_twdl_stage;
	import fft_data_pkg::*;
	import twdl_cfg_pkg::*;

	// Bursts and gaps of all tests add up to well under this.
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int RESET_CYCLES = 16;
	localparam int DEPTH = `TW_ROM_DEPTH;
	localparam real PI = 3.14159265358979323846;

	// One expected output beat, released when cyc reaches due.
	typedef struct packed
	{
		logic [31:0] due;
		logic val;
		factor_t factor;
		lane_vec_t lanes;
	} exp_beat_t;

	logic clk;
	logic rst_n;
	logic cfg_we;
	logic [1:0] cfg_addr;
	tw_addr_t cfg_wdata;
	logic in_val;
	lane_vec_t din;
	logic out_val;
	lane_vec_t dout;

	logic [31:0] lfsr;
	int cyc;
	int cycle_count;
	exp_beat_t exp_q[$];
	int ref_re [DEPTH];
	int ref_im [DEPTH];

	twdl_cfg_t m_shadow;
	twdl_cfg_t m_live;
	cfg_state_e m_state;
	int m_n;
	int m_c;

	twdl_stage twdl_stage_i
	(
		.clk (clk),
		.rst_n (rst_n),
		.cfg_we (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.in_val (in_val),
		.din (din),
		.out_val (out_val),
		.dout (dout)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > TIMEOUT_CYCLES)
				abort_run($sformatf("timeout: run still going after %0d cycles",
					TIMEOUT_CYCLES));
		end
	end

	task automatic check_val(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_lane(input int lane, input cplx_t got, input cplx_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch dout[%0d] got 0x%h expected 0x%h",
				lane, got, exp));
	endtask

	task automatic check_cfg_effect(input lane_vec_t got, input lane_vec_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch dout got 0x%h expected 0x%h", got, exp));
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] r;
		r = s >> 1;
		if (s[0])
			r = r ^ 32'h80200003;
		return r;
	endfunction

	// One LFSR step per bit taken.
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < nbits; b++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic sample_t rand_sample();
		logic [23:0] r;
		r = 24'(rand_bits(24));
		return sample_t'($signed(r));
	endfunction

	function automatic int nearest_int(input real x);
		int r;
		if (x >= 0.0)
			r = int'($floor(x + 0.5));
		else
			r = -int'($floor(0.5 - x));
		return r;
	endfunction

	task automatic build_ref_rom();
		real ang;
		real scale;
		scale = real'((1 << `TW_FRAC) - 1);
		for (int k = 0; k < DEPTH; k++)
		begin
			ang = 2.0 * PI * k / DEPTH;
			ref_re[k] = nearest_int($cos(ang) * scale);
			ref_im[k] = -nearest_int($sin(ang) * scale);
		end
	endtask

	function automatic cplx_t ref_mult(input cplx_t d, input int k);
		longint pr;
		longint pi;
		cplx_t r;
		pr = longint'(d.re) * ref_re[k] - longint'(d.im) * ref_im[k];
		pi = longint'(d.re) * ref_im[k] + longint'(d.im) * ref_re[k];
		r.re = sample_t'(pr >>> `TW_FRAC);
		r.im = sample_t'(pi >>> `TW_FRAC);
		return r;
	endfunction

	// Expected beat for the inputs now driven, then the state after the next edge.
	task automatic model_step();
		exp_beat_t e;
		twdl_cfg_t nxt;
		logic wr_ok;
		int k;
		e.due = 32'(cyc + 2);
		e.val = in_val;
		e.factor = m_live.factor;
		e.lanes = '0;
		if (in_val)
		begin
			for (int i = 0; i < int'(m_live.factor); i++)
			begin
				k = (int'(m_live.addr_step) * m_n * i) % DEPTH;
				e.lanes[i] = ref_mult(din[i], k);
			end
		end
		exp_q.push_back(e);

		if (!in_val)
		begin
			m_n = 0;
			m_c = 0;
		end
		else if (m_c == int'(m_live.exp_time) - 1)
		begin
			m_c = 0;
			if (m_n == int'(m_live.exp_ceil) - 1)
				m_n = 0;
			else
				m_n++;
		end
		else
			m_c++;

		wr_ok = cfg_we && ((cfg_addr != `TW_REG_FACTOR) ||
			((cfg_wdata >= 2) && (cfg_wdata <= 5)));
		nxt = m_shadow;
		if (wr_ok)
		begin
			case (cfg_addr)
				`TW_REG_FACTOR: nxt.factor = factor_t'(cfg_wdata);
				`TW_REG_STEP: nxt.addr_step = cfg_wdata;
				`TW_REG_CEIL: nxt.exp_ceil = (cfg_wdata == 0) ? tw_addr_t'(1) : cfg_wdata;
				`TW_REG_TIME: nxt.exp_time = (cfg_wdata == 0) ? tw_addr_t'(1) : cfg_wdata;
			endcase
		end
		if (!in_val && (wr_ok || (m_state == CFG_PENDING)))
		begin
			m_live = nxt;
			m_state = CFG_IDLE;
		end
		else if (wr_ok)
			m_state = CFG_PENDING;
		m_shadow = nxt;
	endtask

	task automatic check_beat(input exp_beat_t e);
		check_val("out_val", out_val, e.val);
		if (e.val)
		begin
			for (int i = 0; i < int'(e.factor); i++)
				check_lane(i, dout[i], e.lanes[i]);
		end
		check_cfg_effect(dout, e.lanes);
	endtask

	task automatic drive_cycle(input logic we, input logic [1:0] addr,
		input tw_addr_t wdata, input logic val);
		exp_beat_t e;
		@(negedge clk);
		cyc++;
		if ((exp_q.size() > 0) && (exp_q[0].due == cyc))
		begin
			e = exp_q.pop_front();
			check_beat(e);
		end
		cfg_we = we;
		cfg_addr = addr;
		cfg_wdata = wdata;
		in_val = val;
		for (int i = 0; i < `TW_LANES; i++)
		begin
			din[i].re = rand_sample();
			din[i].im = rand_sample();
		end
		model_step();
	endtask

	task automatic run_idle(input int len);
		for (int j = 0; j < len; j++)
			drive_cycle(1'b0, 2'd0, '0, 1'b0);
	endtask

	task automatic write_reg(input logic [1:0] addr, input tw_addr_t data);
		drive_cycle(1'b1, addr, data, 1'b0);
	endtask

	// A wr_at of -1 means no write inside the burst.
	task automatic run_burst(input int len, input int wr_at, input logic [1:0] wr_addr,
		input tw_addr_t wr_data);
		for (int j = 0; j < len; j++)
			drive_cycle(j == wr_at, wr_addr, wr_data, 1'b1);
	endtask

	initial
	begin
		int len;
		tw_addr_t ceil_v;
		tw_addr_t time_v;
		rst_n = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		in_val = 1'b0;
		din = '0;
		lfsr = 32'h2d7c752f;
		cyc = 0;
		build_ref_rom();
		m_live = '{factor: 3'd5, addr_step: 8'd1, exp_ceil: 8'd1, exp_time: 8'd1};
		m_shadow = m_live;
		m_state = CFG_IDLE;
		m_n = 0;
		m_c = 0;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		check_val("out_val", out_val, 1'b0);
		check_cfg_effect(dout, '0);

		// Defaults keep every twiddle index at zero.
		for (int b = 0; b < 6; b++)
		begin
			run_burst(32 + int'(rand_bits(6)), -1, 2'd0, '0);
			run_idle(1 + int'(rand_bits(2)));
		end

		// Random exponent settings, bursts long enough to wrap n.
		for (int r = 0; r < 4; r++)
		begin
			ceil_v = tw_addr_t'(rand_bits(4)) + 8'd1;
			time_v = tw_addr_t'(rand_bits(3)) + 8'd1;
			write_reg(`TW_REG_STEP, tw_addr_t'(rand_bits(8)));
			write_reg(`TW_REG_CEIL, ceil_v);
			write_reg(`TW_REG_TIME, time_v);
			run_idle(2);
			for (int b = 0; b < 2; b++)
			begin
				len = int'(ceil_v) * int'(time_v) + 4 + int'(rand_bits(4));
				run_burst(len, -1, 2'd0, '0);
				run_idle(2);
			end
		end

		// A one-cycle gap mid-pattern sends the next burst back to index 0.
		write_reg(`TW_REG_STEP, 8'd5);
		write_reg(`TW_REG_CEIL, 8'd10);
		write_reg(`TW_REG_TIME, 8'd3);
		run_idle(2);
		run_burst(11, -1, 2'd0, '0);
		run_idle(1);
		run_burst(40, -1, 2'd0, '0);
		run_idle(2);

		for (int f = 2; f <= 5; f++)
		begin
			write_reg(`TW_REG_FACTOR, tw_addr_t'(f));
			run_idle(1);
			run_burst(16, -1, 2'd0, '0);
			run_idle(1);
		end
		write_reg(`TW_REG_FACTOR, 8'd3);
		for (int j = 0; j < 4; j++)
		begin
			write_reg(`TW_REG_FACTOR, tw_addr_t'((j < 2) ? j : j + 4));
			run_idle(1);
			run_burst(12, -1, 2'd0, '0);
			run_idle(1);
		end

		// Writes inside a burst wait for the gap.
		write_reg(`TW_REG_FACTOR, 8'd5);
		write_reg(`TW_REG_STEP, 8'd3);
		write_reg(`TW_REG_CEIL, 8'd8);
		write_reg(`TW_REG_TIME, 8'd1);
		run_idle(2);
		run_burst(30, 8, `TW_REG_FACTOR, 8'd2);
		run_idle(2);
		run_burst(20, -1, 2'd0, '0);
		run_burst(30, 29, `TW_REG_STEP, 8'd11);
		run_idle(1);
		run_burst(20, -1, 2'd0, '0);
		run_idle(2);

		write_reg(`TW_REG_STEP, 8'd9);
		write_reg(`TW_REG_CEIL, 8'd0);
		write_reg(`TW_REG_TIME, 8'd0);
		run_idle(2);
		run_burst(20, -1, 2'd0, '0);
		run_idle(1);
		write_reg(`TW_REG_CEIL, 8'd6);
		run_idle(1);
		run_burst(24, -1, 2'd0, '0);
		run_idle(4);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
hdl/fft_data_pkg.sv
hdl/twdl_cfg_pkg.sv
hdl/twdl_cfg_regs.sv
hdl/twdl_rom.sv
hdl/twdl_mult.sv
hdl/twdl_stage.sv
dv/tb_twdl_stage.sv

//--- Makefile
SRCS := $(shell grep -v '^+' vlog.f) include/twdl_params.svh

obj_dir/Vtb_twdl_stage: vlog.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_twdl_stage \
		-f vlog.f -o Vtb_twdl_stage

sim.log: obj_dir/Vtb_twdl_stage
	./obj_dir/Vtb_twdl_stage > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@grep -qx "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
